// ==== Bender.yml ====
package:
  name: iiq

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/iiq_entry_pkg.sv
      - design/rv_decoder.sv
      - design/iiq_pack.sv
      - design/iiq_unpack.sv
      - design/iiq_fifo.sv
      - design/iiq_wrap.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_clock.sv
      - sim/iiq_tb.sv

// ==== design/iiq_cfg.svh ====
// Queue depth must be a power of two of at least 2; XLEN and PC width are fixed at 32 for RV32I
`ifndef IIQ_CFG_SVH
`define IIQ_CFG_SVH

// Number of queue slots
`define IIQ_DEPTH 4

`define XLEN 32

// Fetch PC width
`define PC_WIDTH 32

`endif

// ==== design/iiq_entry_pkg.sv ====
// Entry layout holds only fields that cannot be re-derived from the word; depends on rv_isa_pkg
`default_nettype none

`include "iiq_cfg.svh"

package iiq_entry_pkg;

    // Per-instruction state known only at fetch time
    typedef struct packed {
        logic [`PC_WIDTH-1:0] pc;
        logic                 pred_taken;
        logic                 fetch_fault;  // Still decoded normally downstream
    } dyn_ctrl_t;

    // What one queue slot actually stores
    typedef struct packed {
        rv_isa_pkg::instr_t instr;
        dyn_ctrl_t          dyn;
    } iiq_entry_t;

endpackage

`default_nettype wire

// ==== design/iiq_fifo.sv ====
// In-order dual-port queue; depth must be a power of two, lane 1 only moves together with lane 0
`timescale 1ns/1ps
`default_nettype none

`include "iiq_cfg.svh"

module iiq_fifo
    import iiq_entry_pkg::*;
(
    input  logic       core_clk,
    input  logic       reset,
    input  logic       flush,
    input  logic [1:0] w_valid,
    output logic [1:0] w_ready,
    input  iiq_entry_t w_entry0,
    input  iiq_entry_t w_entry1,
    output logic [1:0] r_valid,
    input  logic [1:0] r_ready,
    output iiq_entry_t r_entry0,
    output iiq_entry_t r_entry1
);

    localparam int ptr_w = $clog2(`IIQ_DEPTH);
    localparam int cnt_w = $clog2(`IIQ_DEPTH + 1);

    iiq_entry_t       mem [`IIQ_DEPTH];
    logic [ptr_w-1:0] head_q;
    logic [ptr_w-1:0] tail_q;
    logic [ptr_w-1:0] head_p1;
    logic [ptr_w-1:0] tail_p1;
    logic [cnt_w-1:0] count_q;
    logic             push0;
    logic             push1;
    logic             pop0;
    logic             pop1;
    logic [1:0]       n_push;
    logic [1:0]       n_pop;

    // Ready comes from the registered count only, so slots freed this cycle count next cycle
    assign w_ready[0] = (count_q <= cnt_w'(`IIQ_DEPTH - 1));
    assign w_ready[1] = (count_q <= cnt_w'(`IIQ_DEPTH - 2));
    assign r_valid[0] = (count_q != '0);
    assign r_valid[1] = (count_q >= cnt_w'(2));

    assign push0 = w_valid[0] & w_ready[0];
    assign push1 = push0 & w_valid[1] & w_ready[1];
    assign pop0  = r_valid[0] & r_ready[0];
    assign pop1  = pop0 & r_valid[1] & r_ready[1];    // Lane 1 alone pops nothing

    assign n_push = {1'b0, push0} + {1'b0, push1};
    assign n_pop  = {1'b0, pop0} + {1'b0, pop1};

    assign head_p1 = head_q + ptr_w'(1);
    assign tail_p1 = tail_q + ptr_w'(1);

    assign r_entry0 = mem[head_q];   // Oldest entry
    assign r_entry1 = mem[head_p1];

    always_ff @(posedge core_clk) begin
        if (reset || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + ptr_w'(n_pop);
            tail_q  <= tail_q + ptr_w'(n_push);
            count_q <= count_q + cnt_w'(n_push) - cnt_w'(n_pop);
        end
    end

    // A flushed write is harmless since the count is cleared
    always_ff @(posedge core_clk) begin
        if (push0) begin
            mem[tail_q] <= w_entry0;
        end
        if (push1) begin
            mem[tail_p1] <= w_entry1;
        end
    end

    a_count_max: assert property (@(posedge core_clk) disable iff (reset)
        count_q <= cnt_w'(`IIQ_DEPTH));

    // Growth is bounded by the lanes that were ready a cycle earlier
    a_accept_ready: assert property (@(posedge core_clk) disable iff (reset)
        count_q <= $past(count_q) + cnt_w'($past(w_ready[0])) + cnt_w'($past(w_ready[1])));

    a_lane_order: assert property (@(posedge core_clk) disable iff (reset)
        w_valid[1] |-> w_valid[0]);

endmodule

`default_nettype wire

// ==== design/iiq_pack.sv ====
// Write-side compression with zero latency; static input is only checked, never stored
`timescale 1ns/1ps
`default_nettype none

module iiq_pack
    import rv_isa_pkg::*;
    import iiq_entry_pkg::*;
(
    input  logic         core_clk,
    input  logic         valid,
    input  instr_t       instr,
    input  static_ctrl_t static_in,
    input  dyn_ctrl_t    dyn,
    output iiq_entry_t   entry
);

    // Static fields are dropped here and rebuilt by the read-side decoder
    assign entry.instr = instr;
    assign entry.dyn   = dyn;

    // Upstream decode must flag illegal exactly for the illegal class
    a_illegal_class: assert property (@(posedge core_clk)
        valid |-> (static_in.illegal == (static_in.op_class == cls_illegal)));

endmodule

`default_nettype wire

// ==== design/iiq_unpack.sv ====
// Read-side re-decode with zero latency; static fields come only from the stored word
`timescale 1ns/1ps
`default_nettype none

module iiq_unpack
    import rv_isa_pkg::*;
    import iiq_entry_pkg::*;
(
    input  iiq_entry_t   entry,
    output instr_t       instr,
    output static_ctrl_t static_out,
    output dyn_ctrl_t    dyn
);

    rv_decoder u_dec (
        .instr (entry.instr),
        .ctrl  (static_out)
    );

    assign instr = entry.instr;
    assign dyn   = entry.dyn;   // Fetch-time state passes straight through

endmodule

`default_nettype wire

// ==== design/iiq_wrap.sv ====
// Dual-lane issue queue top; read outputs depend on stored state only, never on w_* in the same cycle
`timescale 1ns/1ps
`default_nettype none

module iiq_wrap
    import rv_isa_pkg::*;
    import iiq_entry_pkg::*;
(
    input  logic         core_clk,
    input  logic         reset,
    input  logic         flush,
    input  logic [1:0]   w_valid,
    output logic [1:0]   w_ready,
    input  instr_t       w_instr0,
    input  instr_t       w_instr1,
    input  static_ctrl_t w_static0,
    input  static_ctrl_t w_static1,
    input  dyn_ctrl_t    w_dyn0,
    input  dyn_ctrl_t    w_dyn1,
    output logic [1:0]   r_valid,
    input  logic [1:0]   r_ready,
    output instr_t       r_instr0,
    output instr_t       r_instr1,
    output static_ctrl_t r_static0,
    output static_ctrl_t r_static1,
    output dyn_ctrl_t    r_dyn0,
    output dyn_ctrl_t    r_dyn1
);

    iiq_entry_t w_entry0;
    iiq_entry_t w_entry1;
    iiq_entry_t r_entry0;
    iiq_entry_t r_entry1;

    iiq_pack u_pack0 (
        .core_clk  (core_clk),
        .valid     (w_valid[0]),
        .instr     (w_instr0),
        .static_in (w_static0),
        .dyn       (w_dyn0),
        .entry     (w_entry0)
    );

    iiq_pack u_pack1 (
        .core_clk  (core_clk),
        .valid     (w_valid[1]),
        .instr     (w_instr1),
        .static_in (w_static1),
        .dyn       (w_dyn1),
        .entry     (w_entry1)
    );

    iiq_fifo u_fifo (
        .core_clk (core_clk),
        .reset    (reset),
        .flush    (flush),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_entry0 (w_entry0),
        .w_entry1 (w_entry1),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_entry0 (r_entry0),
        .r_entry1 (r_entry1)
    );

    iiq_unpack u_unpack0 (
        .entry      (r_entry0),
        .instr      (r_instr0),
        .static_out (r_static0),
        .dyn        (r_dyn0)
    );

    iiq_unpack u_unpack1 (
        .entry      (r_entry1),
        .instr      (r_instr1),
        .static_out (r_static1),
        .dyn        (r_dyn1)
    );

endmodule

`default_nettype wire

// ==== design/rv_decoder.sv ====
// Purely combinational RV32I base decoder; no CSR, privilege or compressed instruction support
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
    import rv_isa_pkg::*;
(
    input  instr_t       instr,
    output static_ctrl_t ctrl
);

    logic cls_writes;   // Class writes rd before the x0 check

    always_comb begin
        ctrl       = '0;
        cls_writes = 1'b0;
        // Register fields are taken raw whatever the format
        ctrl.rd  = instr[11:7];
        ctrl.rs1 = instr[19:15];
        ctrl.rs2 = instr[24:20];
        case (instr[6:0])
            opc_lui: begin
                ctrl.op_class = cls_lui;
                ctrl.imm      = imm_u(instr);
                cls_writes    = 1'b1;
            end
            opc_auipc: begin
                ctrl.op_class = cls_auipc;
                ctrl.imm      = imm_u(instr);
                cls_writes    = 1'b1;
            end
            opc_jal: begin
                ctrl.op_class = cls_jal;
                ctrl.imm      = imm_j(instr);
                cls_writes    = 1'b1;
            end
            opc_jalr: begin
                ctrl.op_class = cls_jalr;
                ctrl.imm      = imm_i(instr);
                cls_writes    = 1'b1;
            end
            opc_branch: begin
                ctrl.op_class = cls_branch;
                ctrl.imm      = imm_b(instr);
            end
            opc_load: begin
                ctrl.op_class = cls_load;
                ctrl.imm      = imm_i(instr);
                cls_writes    = 1'b1;
            end
            opc_store: begin
                ctrl.op_class = cls_store;
                ctrl.imm      = imm_s(instr);
            end
            opc_op_imm: begin
                ctrl.op_class = cls_op_imm;
                ctrl.imm      = imm_i(instr);
                cls_writes    = 1'b1;
            end
            opc_op: begin
                ctrl.op_class = cls_op;     // R-type has no immediate
                cls_writes    = 1'b1;
            end
            default: begin
                ctrl.op_class = cls_illegal;
                ctrl.illegal  = 1'b1;
            end
        endcase
        ctrl.writes_rd = cls_writes && (instr[11:7] != 5'd0);  // x0 is never written
    end

    // A known word must never leave X on the regenerated fields
    always_comb begin
        if (!$isunknown(instr)) begin
            a_ctrl_known: assert #0 (!$isunknown(ctrl));
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
// RV32I base opcodes only; immediate helpers assume a 32-bit word and XLEN of 32
`default_nettype none

`include "iiq_cfg.svh"

package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [`XLEN-1:0] xlen_t;

    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_illegal
    } op_class_t;

    // Major opcodes in bits 6:0
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // Everything here can be rebuilt from the instruction word
    typedef struct packed {
        op_class_t   op_class;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        xlen_t       imm;       // Sign-extended per format
        logic        writes_rd;
        logic        illegal;
    } static_ctrl_t;

    function automatic xlen_t imm_i(instr_t w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic xlen_t imm_s(instr_t w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic xlen_t imm_b(instr_t w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic xlen_t imm_u(instr_t w);
        return {w[31:12], 12'b0};
    endfunction

    function automatic xlen_t imm_j(instr_t w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/rv_isa_pkg.sv
design/iiq_entry_pkg.sv
design/rv_decoder.sv
design/iiq_pack.sv
design/iiq_unpack.sv
design/iiq_fifo.sv
design/iiq_wrap.sv
sim/tb_clock.sv
sim/iiq_tb.sv

// ==== sim/iiq_tb.sv ====
// Table-driven check of iiq_wrap against an in-order queue model; fill rows assume a depth of 4
`timescale 1ns/1ps
`default_nettype none

`include "iiq_cfg.svh"

module iiq_tb
    import rv_isa_pkg::*;
    import iiq_entry_pkg::*;
();

    typedef struct {
        logic [1:0] wv;
        instr_t     i0;
        instr_t     i1;
        dyn_ctrl_t  d0;
        dyn_ctrl_t  d1;
        logic [1:0] rr;
        logic       fl;
        int         test;
    } row_t;

    // One word per decode class, plus rd of 0 and illegal opcodes
    localparam instr_t class_words [12] = '{
        32'h123452b7, 32'hfffff097, 32'h800000ef, 32'h00008067,
        32'hfe208ee3, 32'hffc12503, 32'h00a12223, 32'h00000013,
        32'h002081b3, 32'hffffffff, 32'h0000000b, 32'h00001037
    };
    localparam logic [6:0] opc_pool [10] = '{
        7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33, 7'h7f
    };

    logic         core_clk;
    logic         reset;
    logic         flush;
    logic [1:0]   w_valid;
    logic [1:0]   w_ready;
    logic [1:0]   r_valid;
    logic [1:0]   r_ready;
    instr_t       w_instr0;
    instr_t       w_instr1;
    instr_t       r_instr0;
    instr_t       r_instr1;
    static_ctrl_t w_static0;
    static_ctrl_t w_static1;
    static_ctrl_t r_static0;
    static_ctrl_t r_static1;
    dyn_ctrl_t    w_dyn0;
    dyn_ctrl_t    w_dyn1;
    dyn_ctrl_t    r_dyn0;
    dyn_ctrl_t    r_dyn1;

    row_t        rows [$];
    iiq_entry_t  model [$];     // Oldest entry at the front
    string       test_names [$];
    logic [31:0] lfsr_state = 32'hc744_7f97;
    logic [31:0] pc_ctr = 32'h0000_1000;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    tb_clock u_clk (.clk(core_clk));

    iiq_wrap uut (.*);

    function automatic static_ctrl_t decode_ref(instr_t w);
        static_ctrl_t c;
        c = '0;
        c.rd  = w[11:7];
        c.rs1 = w[19:15];
        c.rs2 = w[24:20];
        case (w[6:0])
            7'h37: c.op_class = cls_lui;
            7'h17: c.op_class = cls_auipc;
            7'h6f: c.op_class = cls_jal;
            7'h67: c.op_class = cls_jalr;
            7'h63: c.op_class = cls_branch;
            7'h03: c.op_class = cls_load;
            7'h23: c.op_class = cls_store;
            7'h13: c.op_class = cls_op_imm;
            7'h33: c.op_class = cls_op;
            default: c.op_class = cls_illegal;
        endcase
        case (c.op_class)
            cls_lui, cls_auipc: c.imm = {w[31:12], 12'h000};
            cls_jal: c.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            cls_jalr, cls_load, cls_op_imm: c.imm = {{21{w[31]}}, w[30:20]};
            cls_store: c.imm = {{21{w[31]}}, w[30:25], w[11:7]};
            cls_branch: c.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            default: c.imm = '0;
        endcase
        c.illegal   = (c.op_class == cls_illegal);
        c.writes_rd = (w[11:7] != 5'd0) && !c.illegal
                      && c.op_class != cls_branch && c.op_class != cls_store;
        return c;
    endfunction

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 32'ha300_0000;  // Taps 32, 30, 26, 25
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        repeat (n) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic instr_t rand_instr();
        logic [31:0] sel;
        logic [31:0] hi;
        sel = rand_bits(4);
        hi  = rand_bits(25);
        return {hi[24:0], opc_pool[sel % 10]};
    endfunction

    function automatic dyn_ctrl_t rand_dyn();
        dyn_ctrl_t d;
        d.pc          = rand_bits(32);
        d.pred_taken  = lfsr_bit();
        d.fetch_fault = lfsr_bit();
        return d;
    endfunction

    function automatic dyn_ctrl_t next_dyn();
        pc_ctr = pc_ctr + 32'd4;
        return {pc_ctr, pc_ctr[2], pc_ctr[4]};
    endfunction

    task automatic add_row(logic [1:0] wv, instr_t i0, instr_t i1, logic [1:0] rr, logic fl);
        dyn_ctrl_t d0;
        dyn_ctrl_t d1;
        d0 = next_dyn();
        d1 = next_dyn();
        rows.push_back(row_t'{wv, i0, i1, d0, d1, rr, fl, test_names.size() - 1});
    endtask

    task automatic build_table();
        row_t        r;
        logic [31:0] sel;
        test_names.push_back("reset state");
        add_row(2'b00, '0, '0, 2'b00, 1'b0);
        test_names.push_back("decode classes");
        foreach (class_words[k])
            add_row(2'b01, class_words[k], '0, 2'b01, 1'b0);
        add_row(2'b00, '0, '0, 2'b01, 1'b0);
        test_names.push_back("dual lane order");
        add_row(2'b11, 32'h00100093, 32'h00200113, 2'b00, 1'b0);
        add_row(2'b00, '0, '0, 2'b10, 1'b0);    // Lane 1 alone
        add_row(2'b11, 32'h00300193, 32'h00400213, 2'b11, 1'b0);
        add_row(2'b00, '0, '0, 2'b01, 1'b0);
        add_row(2'b00, '0, '0, 2'b11, 1'b0);
        test_names.push_back("fill and drain");
        repeat (4) add_row(2'b01, 32'h00500293, '0, 2'b00, 1'b0);
        add_row(2'b11, 32'h00600313, 32'h00700393, 2'b00, 1'b0);
        add_row(2'b01, 32'h00800413, '0, 2'b01, 1'b0);  // Pop while full frees a slot too late
        add_row(2'b00, '0, '0, 2'b11, 1'b0);
        add_row(2'b00, '0, '0, 2'b11, 1'b0);
        add_row(2'b00, '0, '0, 2'b00, 1'b0);
        test_names.push_back("flush");
        add_row(2'b11, 32'h00900493, 32'h00a00513, 2'b00, 1'b0);
        add_row(2'b01, 32'h00b00593, '0, 2'b00, 1'b0);
        add_row(2'b11, 32'h00c00613, 32'h00d00693, 2'b01, 1'b1);
        add_row(2'b01, 32'h00e00713, '0, 2'b00, 1'b0);
        add_row(2'b00, '0, '0, 2'b00, 1'b1);
        add_row(2'b00, '0, '0, 2'b01, 1'b0);
        test_names.push_back("random traffic");
        repeat (200) begin
            r.i0   = rand_instr();
            r.i1   = rand_instr();
            r.d0   = rand_dyn();
            r.d1   = rand_dyn();
            sel    = rand_bits(2);
            r.wv   = {sel[1] & sel[0], sel[0]};
            r.rr   = rand_bits(2);
            r.fl   = (rand_bits(5) == 0);
            r.test = test_names.size() - 1;
            rows.push_back(r);
        end
        repeat (3) add_row(2'b00, '0, '0, 2'b11, 1'b0);
    endtask

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        errors++;
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic check_static(string name, static_ctrl_t got, static_ctrl_t exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_dyn(string name, dyn_ctrl_t got, dyn_ctrl_t exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_instr(string name, instr_t got, instr_t exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_flags(string name, logic [1:0] got, logic [1:0] exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_outputs();
        int cnt;
        cnt = model.size();
        check_flags("r_valid", r_valid, {cnt >= 2, cnt >= 1});
        check_flags("w_ready", w_ready, {cnt <= `IIQ_DEPTH - 2, cnt <= `IIQ_DEPTH - 1});
        if (cnt >= 1) begin
            check_instr("r_instr0", r_instr0, model[0].instr);
            check_static("r_static0", r_static0, decode_ref(model[0].instr));
            check_dyn("r_dyn0", r_dyn0, model[0].dyn);
        end
        if (cnt >= 2) begin
            check_instr("r_instr1", r_instr1, model[1].instr);
            check_static("r_static1", r_static1, decode_ref(model[1].instr));
            check_dyn("r_dyn1", r_dyn1, model[1].dyn);
        end
    endtask

    task automatic drive_row(row_t r);
        w_valid   = r.wv;
        w_instr0  = r.i0;
        w_instr1  = r.i1;
        w_static0 = decode_ref(r.i0);   // Upstream decode of the same word
        w_static1 = decode_ref(r.i1);
        w_dyn0    = r.d0;
        w_dyn1    = r.d1;
        r_ready   = r.rr;
        flush     = r.fl;
    endtask

    // Ready and valid come from the occupancy before the edge
    task automatic update_model(row_t r);
        int   cnt;
        logic pop0;
        logic pop1;
        logic push0;
        logic push1;
        cnt   = model.size();
        pop0  = r.rr[0] && cnt >= 1;
        pop1  = pop0 && r.rr[1] && cnt >= 2;
        push0 = r.wv[0] && cnt <= `IIQ_DEPTH - 1;
        push1 = push0 && r.wv[1] && cnt <= `IIQ_DEPTH - 2;
        if (r.fl) begin
            model.delete();
        end else begin
            if (pop0) void'(model.pop_front());
            if (pop1) void'(model.pop_front());
            if (push0) model.push_back({r.i0, r.d0});
            if (push1) model.push_back({r.i1, r.d1});
        end
    endtask

    task automatic report_test(int idx, int err_mark);
        $display("done %s, %0d errors", test_names[idx], errors - err_mark);
    endtask

    initial begin
        int prev;
        int err_mark;
        reset     = 1'b1;
        flush     = 1'b0;
        w_valid   = 2'b00;
        w_instr0  = '0;
        w_instr1  = '0;
        w_static0 = '0;
        w_static1 = '0;
        w_dyn0    = '0;
        w_dyn1    = '0;
        r_ready   = 2'b00;
        build_table();
        cycle_limit = 2 * rows.size() + 100;
        repeat (10) @(negedge core_clk);
        reset    = 1'b0;
        prev     = 0;
        err_mark = 0;
        foreach (rows[k]) begin
            @(negedge core_clk);
            check_outputs();    // Result of the previous row
            if (rows[k].test != prev) begin
                report_test(prev, err_mark);
                prev     = rows[k].test;
                err_mark = errors;
            end
            drive_row(rows[k]);
            update_model(rows[k]);
        end
        @(negedge core_clk);
        check_outputs();
        report_test(prev, err_mark);
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    always @(posedge core_clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the stimulus table did not finish", cycles);
            $display("test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
// Free-running testbench clock that starts low; the period is set in ns
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period = 8.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2.0) clk = ~clk;  // First rising edge at half a period

endmodule

`default_nettype wire
